/* common/rvCore_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data, address and instruction width
`define RV_XLEN 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Register index width, 32 registers
`define RV_REG_BITS 5

// Instruction field positions
`define RV_OPC_LSB 0
`define RV_RD_LSB 7
`define RV_F3_LSB 12
`define RV_RS1_LSB 15
`define RV_RS2_LSB 20
`define RV_F7_LSB 25

`endif

/* common/rvCorePkg.sv */
`default_nettype none

`include "rvCore_config.svh"

package rvCorePkg;

	typedef logic [`RV_XLEN-1:0] wordT;
	typedef logic [`RV_REG_BITS-1:0] regIdxT;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		LUI    = 7'b0110111,
		JAL    = 7'b1101111
	} opcodeT;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLL,
		SRL,
		SRA,
		PASS_B
	} aluOpT;

	typedef enum logic [2:0] {
		NONE,
		EQ,
		NE,
		LT,
		GE,
		ALWAYS
	} branchCondT;

	typedef enum logic [1:0] {
		ALU,
		MEM,
		LINK
	} wbSelT;

endpackage

`default_nettype wire

/* source/instrDecoder.sv */
`default_nettype none

`include "rvCore_config.svh"

module instrDecoder (
	input rvCorePkg::wordT instr,
	output rvCorePkg::regIdxT rs1,
	output rvCorePkg::regIdxT rs2,
	output rvCorePkg::regIdxT rd,
	output rvCorePkg::wordT imm,
	output rvCorePkg::aluOpT aluOp,
	output logic useImm,
	output logic regWrite,
	output logic memWrite,
	output logic isLoad,
	output rvCorePkg::branchCondT branchCond,
	output rvCorePkg::wbSelT wbSel,
	output logic readsRs1,
	output logic readsRs2
);
	import rvCorePkg::*;

	opcodeT opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	wordT immI;
	wordT immS;
	wordT immB;
	wordT immU;
	wordT immJ;

	assign opcode = opcodeT'(instr[`RV_OPC_LSB +: 7]);
	assign funct3 = instr[`RV_F3_LSB +: 3];
	assign funct7 = instr[`RV_F7_LSB +: 7];
	assign rs1 = instr[`RV_RS1_LSB +: `RV_REG_BITS];
	assign rs2 = instr[`RV_RS2_LSB +: `RV_REG_BITS];
	assign rd = instr[`RV_RD_LSB +: `RV_REG_BITS];

	// Sign-extended immediates per format
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// Anything not matched below stays a no-op
		imm = immI;
		aluOp = ADD;
		useImm = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		isLoad = 1'b0;
		branchCond = NONE;
		wbSel = ALU;
		readsRs1 = 1'b0;
		readsRs2 = 1'b0;
		case (opcode)
			OP: begin
				readsRs1 = 1'b1;
				readsRs2 = 1'b1;
				regWrite = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'h0}: aluOp = ADD;
					{7'h20, 3'h0}: aluOp = SUB;
					{7'h00, 3'h1}: aluOp = SLL;
					{7'h00, 3'h2}: aluOp = SLT;
					{7'h00, 3'h4}: aluOp = XOR;
					{7'h00, 3'h5}: aluOp = SRL;
					{7'h20, 3'h5}: aluOp = SRA;
					{7'h00, 3'h6}: aluOp = OR;
					{7'h00, 3'h7}: aluOp = AND;
					default: begin
						readsRs1 = 1'b0;
						readsRs2 = 1'b0;
						regWrite = 1'b0;
					end
				endcase
			end
			OP_IMM: begin
				readsRs1 = 1'b1;
				useImm = 1'b1;
				regWrite = 1'b1;
				case (funct3)
					3'h0: aluOp = ADD;
					3'h2: aluOp = SLT;
					3'h4: aluOp = XOR;
					3'h6: aluOp = OR;
					3'h7: aluOp = AND;
					default: begin
						readsRs1 = 1'b0;
						regWrite = 1'b0;
					end
				endcase
			end
			LOAD: begin
				// Word loads only
				if (funct3 == 3'h2) begin
					readsRs1 = 1'b1;
					useImm = 1'b1;
					regWrite = 1'b1;
					isLoad = 1'b1;
					wbSel = MEM;
				end
			end
			STORE: begin
				if (funct3 == 3'h2) begin
					imm = immS;
					readsRs1 = 1'b1;
					readsRs2 = 1'b1;
					useImm = 1'b1;
					memWrite = 1'b1;
				end
			end
			BRANCH: begin
				imm = immB;
				readsRs1 = 1'b1;
				readsRs2 = 1'b1;
				case (funct3)
					3'h0: branchCond = EQ;
					3'h1: branchCond = NE;
					3'h4: branchCond = LT;
					3'h5: branchCond = GE;
					default: begin
						readsRs1 = 1'b0;
						readsRs2 = 1'b0;
					end
				endcase
			end
			LUI: begin
				imm = immU;
				useImm = 1'b1;
				aluOp = PASS_B;
				regWrite = 1'b1;
			end
			JAL: begin
				imm = immJ;
				branchCond = ALWAYS;
				regWrite = 1'b1;
				wbSel = LINK;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/regFile.sv */
`default_nettype none

module regFile (
	input logic clk,
	input rvCorePkg::regIdxT rs1,
	input rvCorePkg::regIdxT rs2,
	input rvCorePkg::regIdxT rd,
	input logic writeEnable,
	input rvCorePkg::wordT writeData,
	output rvCorePkg::wordT rs1Data,
	output rvCorePkg::wordT rs2Data
);
	import rvCorePkg::*;

	// x0 has no storage
	wordT regs [1:31];

	function automatic wordT readPort(input regIdxT idx);
		if (idx == '0) begin
			return '0;
		end else if (writeEnable && idx == rd) begin
			// Same-cycle write shows through
			return writeData;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (writeEnable && rd != '0) begin
			regs[rd] <= writeData;
		end
	end

	always_comb begin
		rs1Data = readPort(rs1);
		rs2Data = readPort(rs2);
	end

endmodule

`default_nettype wire

/* source/alu.sv */
`default_nettype none

module alu (
	input rvCorePkg::aluOpT aluOp,
	input rvCorePkg::wordT a,
	input rvCorePkg::wordT b,
	input rvCorePkg::branchCondT branchCond,
	output rvCorePkg::wordT result,
	output logic branchTaken
);
	import rvCorePkg::*;

	logic signedLess;
	logic equal;
	logic [4:0] shamt;

	assign signedLess = $signed(a) < $signed(b);
	assign equal = a == b;
	assign shamt = b[4:0];

	always_comb begin
		case (aluOp)
			ADD: result = a + b;
			SUB: result = a - b;
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			SLT: result = wordT'(signedLess);
			SLL: result = a << shamt;
			SRL: result = a >> shamt;
			SRA: result = wordT'($signed(a) >>> shamt);
			PASS_B: result = b;
			default: result = '0;
		endcase
	end

	// Compares the register operands directly
	always_comb begin
		case (branchCond)
			EQ: branchTaken = equal;
			NE: branchTaken = !equal;
			LT: branchTaken = signedLess;
			GE: branchTaken = !signedLess;
			ALWAYS: branchTaken = 1'b1;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
`default_nettype none

module hazardUnit (
	input rvCorePkg::regIdxT idRs1,
	input rvCorePkg::regIdxT idRs2,
	input rvCorePkg::regIdxT exRs1,
	input rvCorePkg::regIdxT exRs2,
	input rvCorePkg::regIdxT exRd,
	input rvCorePkg::regIdxT memRd,
	input rvCorePkg::regIdxT wbRd,
	input logic idReadsRs1,
	input logic idReadsRs2,
	input logic exValidLoad,
	input logic memRegWrite,
	input logic wbRegWrite,
	input logic redirect,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB,
	output logic stall,
	output logic flush
);
	import rvCorePkg::*;

	logic loadUse;

	// 2'b10 takes the EX/MEM result, 2'b01 the writeback value
	function automatic logic [1:0] forwardSelect(
		input regIdxT src,
		input regIdxT memDest,
		input logic memWrites,
		input regIdxT wbDest,
		input logic wbWrites
	);
		if (memWrites && memDest != '0 && memDest == src) begin
			return 2'b10;
		end else if (wbWrites && wbDest != '0 && wbDest == src) begin
			return 2'b01;
		end
		return 2'b00;
	endfunction

	assign fwdA = forwardSelect(exRs1, memRd, memRegWrite, wbRd, wbRegWrite);
	assign fwdB = forwardSelect(exRs2, memRd, memRegWrite, wbRd, wbRegWrite);

	assign loadUse = exValidLoad && exRd != '0
		&& ((idReadsRs1 && idRs1 == exRd) || (idReadsRs2 && idRs2 == exRd));

	// Redirect kills the stalled instruction anyway
	assign flush = redirect;
	assign stall = loadUse && !redirect;

endmodule

`default_nettype wire

/* source/rvCore.sv */
`default_nettype none

`include "rvCore_config.svh"

module rvCore (
	input logic clk,
	input logic reset,
	output rvCorePkg::wordT instrAddr,
	input rvCorePkg::wordT instrData,
	output rvCorePkg::wordT dataAddr,
	output rvCorePkg::wordT dataWriteData,
	output logic dataWrite,
	input rvCorePkg::wordT dataReadData
);
	import rvCorePkg::*;

	wordT pc;
	logic ifIdValid;
	wordT ifIdPc;
	wordT ifIdInstr;

	regIdxT decRs1;
	regIdxT decRs2;
	regIdxT decRd;
	wordT decImm;
	aluOpT decAluOp;
	logic decUseImm;
	logic decRegWrite;
	logic decMemWrite;
	logic decIsLoad;
	branchCondT decBranchCond;
	wbSelT decWbSel;
	logic decReadsRs1;
	logic decReadsRs2;
	wordT rs1Data;
	wordT rs2Data;

	logic idExValid;
	wordT idExPc;
	regIdxT idExRs1;
	regIdxT idExRs2;
	regIdxT idExRd;
	wordT idExRs1Data;
	wordT idExRs2Data;
	wordT idExImm;
	aluOpT idExAluOp;
	logic idExUseImm;
	logic idExRegWrite;
	logic idExMemWrite;
	logic idExIsLoad;
	branchCondT idExBranchCond;
	wbSelT idExWbSel;

	logic [1:0] fwdA;
	logic [1:0] fwdB;
	wordT opA;
	wordT opB;
	wordT aluB;
	wordT aluResult;
	logic branchTaken;
	logic redirect;
	wordT branchTarget;
	logic stall;
	logic flush;

	logic exMemValid;
	regIdxT exMemRd;
	wordT exMemAlu;
	wordT exMemLink;
	wordT exMemStoreData;
	logic exMemRegWrite;
	logic exMemMemWrite;
	wbSelT exMemWbSel;
	logic memRegWrite;

	logic memWbValid;
	regIdxT memWbRd;
	wordT memWbAlu;
	wordT memWbLoad;
	wordT memWbLink;
	logic memWbRegWrite;
	wbSelT memWbWbSel;
	logic wbRegWrite;
	wordT wbData;

	function automatic wordT forwardMux(
		input logic [1:0] sel,
		input wordT regVal,
		input wordT memVal,
		input wordT wbVal
	);
		case (sel)
			2'b10: return memVal;
			2'b01: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// Fetch
	assign instrAddr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RV_RESET_PC;
		end else if (redirect) begin
			pc <= branchTarget;
		end else if (!stall) begin
			pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			ifIdValid <= 1'b0;
		end else if (!stall) begin
			ifIdValid <= 1'b1;
		end
		if (!stall) begin
			ifIdPc <= pc;
			ifIdInstr <= instrData;
		end
	end

	// Decode
	instrDecoder i_instrDecoder (
		.instr(ifIdInstr),
		.rs1(decRs1),
		.rs2(decRs2),
		.rd(decRd),
		.imm(decImm),
		.aluOp(decAluOp),
		.useImm(decUseImm),
		.regWrite(decRegWrite),
		.memWrite(decMemWrite),
		.isLoad(decIsLoad),
		.branchCond(decBranchCond),
		.wbSel(decWbSel),
		.readsRs1(decReadsRs1),
		.readsRs2(decReadsRs2)
	);

	regFile i_regFile (
		.clk(clk),
		.rs1(decRs1),
		.rs2(decRs2),
		.rd(memWbRd),
		.writeEnable(wbRegWrite),
		.writeData(wbData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	always_ff @(posedge clk) begin
		// Stall inserts a bubble here
		if (reset || flush || stall) begin
			idExValid <= 1'b0;
		end else begin
			idExValid <= ifIdValid;
		end
		idExPc <= ifIdPc;
		idExRs1 <= decRs1;
		idExRs2 <= decRs2;
		idExRd <= decRd;
		idExRs1Data <= rs1Data;
		idExRs2Data <= rs2Data;
		idExImm <= decImm;
		idExAluOp <= decAluOp;
		idExUseImm <= decUseImm;
		idExRegWrite <= decRegWrite;
		idExMemWrite <= decMemWrite;
		idExIsLoad <= decIsLoad;
		idExBranchCond <= decBranchCond;
		idExWbSel <= decWbSel;
	end

	// Execute
	// Loads and JAL never have a valid consumer here while in memory
	assign opA = forwardMux(fwdA, idExRs1Data, exMemAlu, wbData);
	assign opB = forwardMux(fwdB, idExRs2Data, exMemAlu, wbData);
	assign aluB = idExUseImm ? idExImm : opB;
	assign branchTarget = idExPc + idExImm;
	assign redirect = idExValid && branchTaken;

	alu i_alu (
		.aluOp(idExAluOp),
		.a(opA),
		.b(aluB),
		.branchCond(idExBranchCond),
		.result(aluResult),
		.branchTaken(branchTaken)
	);

	hazardUnit i_hazardUnit (
		.idRs1(decRs1),
		.idRs2(decRs2),
		.exRs1(idExRs1),
		.exRs2(idExRs2),
		.exRd(idExRd),
		.memRd(exMemRd),
		.wbRd(memWbRd),
		.idReadsRs1(decReadsRs1),
		.idReadsRs2(decReadsRs2),
		.exValidLoad(idExValid && idExIsLoad),
		.memRegWrite(memRegWrite),
		.wbRegWrite(wbRegWrite),
		.redirect(redirect),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stall(stall),
		.flush(flush)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			exMemValid <= 1'b0;
		end else begin
			exMemValid <= idExValid;
		end
		exMemRd <= idExRd;
		exMemAlu <= aluResult;
		exMemLink <= idExPc + 32'd4;
		exMemStoreData <= opB;
		exMemRegWrite <= idExRegWrite;
		exMemMemWrite <= idExMemWrite;
		exMemWbSel <= idExWbSel;
	end

	// Memory
	assign dataAddr = exMemAlu;
	assign dataWriteData = exMemStoreData;
	assign dataWrite = exMemValid && exMemMemWrite;
	assign memRegWrite = exMemValid && exMemRegWrite;

	always_ff @(posedge clk) begin
		if (reset) begin
			memWbValid <= 1'b0;
		end else begin
			memWbValid <= exMemValid;
		end
		memWbRd <= exMemRd;
		memWbAlu <= exMemAlu;
		memWbLoad <= dataReadData;
		memWbLink <= exMemLink;
		memWbRegWrite <= exMemRegWrite;
		memWbWbSel <= exMemWbSel;
	end

	// Writeback
	assign wbRegWrite = memWbValid && memWbRegWrite;

	always_comb begin
		case (memWbWbSel)
			MEM: wbData = memWbLoad;
			LINK: wbData = memWbLink;
			default: wbData = memWbAlu;
		endcase
	end

endmodule

`default_nettype wire

/* tests/rvCoreTests.svh */
`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

wordT stepTag;

task automatic testReset();
	startProgram();
	// Store sits at the fetch address for the whole reset
	storeReg(5'd0, 32'd0);
	loadConst(5'd1, 32'h1234_5678);
	storeReg(5'd1, 32'h1234_5678);
	runProgram("reset");
endtask

task automatic testAluChains();
	aluOpT regOps [9];
	aluOpT immOps [5];
	wordT a;
	wordT b;
	wordT acc;
	wordT other;
	wordT rnd;
	logic [11:0] imm;
	// SLT last so the chain keeps wide values longer
	regOps = '{ADD, SUB, SLL, XOR, SRL, OR, SRA, AND, SLT};
	immOps = '{ADD, XOR, OR, AND, SLT};
	a = $random(seed);
	b = $random(seed);
	startProgram();
	loadConst(5'd2, b);
	loadConst(5'd3, a);
	acc = a;
	foreach (regOps[i]) begin
		acc = refAlu(regOps[i], acc, b);
		other = refAlu(regOps[i], b, acc);
		emit(encOp(regOps[i], 5'd3, 5'd3, 5'd2));
		emit(encOp(regOps[i], 5'd4, 5'd2, 5'd3));
		storeReg(5'd3, acc);
		storeReg(5'd4, other);
	end
	loadConst(5'd3, a);
	acc = a;
	foreach (immOps[i]) begin
		rnd = $random(seed);
		imm = rnd[11:0];
		acc = refAlu(immOps[i], acc, {{20{imm[11]}}, imm});
		emit(encI(OP_IMM, funct3Of(immOps[i]), 5'd3, 5'd3, imm));
		storeReg(5'd3, acc);
	end
	runProgram("alu chains");
endtask

task automatic testLoadStore();
	wordT addr;
	startProgram();
	emit(encU(5'd6, 20'habcde));
	addr = nextAddr;
	storeReg(5'd6, 32'habcd_e000);
	// Both loads feed the very next instruction
	emit(encI(LOAD, 3'h2, 5'd7, 5'd0, addr[11:0]));
	emit(encI(OP_IMM, 3'h0, 5'd8, 5'd7, 12'h005));
	storeReg(5'd8, 32'habcd_e005);
	emit(encI(LOAD, 3'h2, 5'd9, 5'd0, addr[11:0]));
	storeReg(5'd9, 32'habcd_e000);
	runProgram("load store");
endtask

task automatic branchCase(input logic [2:0] f3, input regIdxT rs1, input regIdxT rs2,
	input logic taken);
	emit(encB(f3, rs1, rs2, 13'd12));
	if (taken) begin
		// Marker stores to 0xfc
		emit(encS(5'd10, 5'd0, 12'h0fc));
		emit(encS(5'd10, 5'd0, 12'h0fc));
	end else begin
		storeReg(5'd1, 32'hffff_fffb);
		storeReg(5'd2, 32'd7);
	end
	emit(encI(OP_IMM, 3'h0, 5'd12, 5'd12, 12'h001));
	stepTag++;
	storeReg(5'd12, stepTag);
endtask

task automatic testBranches();
	startProgram();
	loadConst(5'd1, 32'hffff_fffb);
	loadConst(5'd10, 32'hbad0_bad0);
	emit(encI(OP_IMM, 3'h0, 5'd12, 5'd0, 12'h000));
	loadConst(5'd2, 32'd7);
	stepTag = '0;
	branchCase(3'h0, 5'd1, 5'd1, 1'b1);
	branchCase(3'h0, 5'd1, 5'd2, 1'b0);
	branchCase(3'h1, 5'd1, 5'd2, 1'b1);
	branchCase(3'h1, 5'd1, 5'd1, 1'b0);
	branchCase(3'h4, 5'd1, 5'd2, 1'b1);
	branchCase(3'h4, 5'd2, 5'd1, 1'b0);
	branchCase(3'h5, 5'd2, 5'd1, 1'b1);
	branchCase(3'h5, 5'd1, 5'd2, 1'b0);
	runProgram("branches");
endtask

task automatic testJal();
	wordT linkAddr;
	startProgram();
	loadConst(5'd10, 32'hbad0_bad0);
	linkAddr = progLen * 4 + 4;
	emit(encJ(5'd5, 21'd12));
	emit(encS(5'd10, 5'd0, 12'h0fc));
	emit(encS(5'd10, 5'd0, 12'h0fc));
	storeReg(5'd5, linkAddr);
	emit(encOp(ADD, 5'd6, 5'd5, 5'd5));
	storeReg(5'd6, linkAddr + linkAddr);
	runProgram("jal");
endtask

task automatic testZeroReg();
	startProgram();
	emit(encI(OP_IMM, 3'h0, 5'd0, 5'd0, 12'h123));
	storeReg(5'd0, 32'd0);
	loadConst(5'd0, 32'hffff_f123);
	emit(encOp(ADD, 5'd0, 5'd0, 5'd0));
	storeReg(5'd0, 32'd0);
	// Fill word at 0xf0 is nonzero
	emit(encI(LOAD, 3'h2, 5'd0, 5'd0, 12'h0f0));
	storeReg(5'd0, 32'd0);
	runProgram("zero register");
endtask

`endif

/* tests/rvCoreTb.sv */
`default_nettype none

`include "rvCore_config.svh"

module rvCoreTb;
	import rvCorePkg::*;

	logic clk;
	logic reset = 1'b1;
	wordT instrAddr;
	wordT instrData;
	wordT dataAddr;
	wordT dataWriteData;
	logic dataWrite;
	wordT dataReadData;

	// 512 bytes of program, 256 bytes of data
	wordT imem [0:127];
	wordT dmem [0:63];

	wordT storeAddrs [$];
	wordT storeData [$];
	wordT expAddrs [$];
	wordT expData [$];

	int errorCount = 0;
	int missingCount = 0;
	int cycleCount = 0;
	int startCycle = 0;
	int cycleLimit = 1000;
	int progLen = 0;
	wordT nextAddr = '0;
	int seed = 32'he25b_dc87;

	rvCore i_rvCore (
		.clk(clk),
		.reset(reset),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.dataAddr(dataAddr),
		.dataWriteData(dataWriteData),
		.dataWrite(dataWrite),
		.dataReadData(dataReadData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	assign instrData = imem[instrAddr[8:2]];
	assign dataReadData = reset ? '0 : dmem[dataAddr[7:2]];

	// Data memory write port and store log
	always @(posedge clk) begin
		if (reset) begin
			storeAddrs.delete();
			storeData.delete();
			for (int i = 0; i < 64; i++) begin
				dmem[i] <= 32'hd0d0_0000 + wordT'(i * 4);
			end
		end else if (dataWrite) begin
			dmem[dataAddr[7:2]] <= dataWriteData;
			storeAddrs.push_back(dataAddr);
			storeData.push_back(dataWriteData);
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount - startCycle > cycleLimit) begin
			$display("Timeout: program did not finish within %0d cycles", cycleLimit);
			$display("Errors: %0d mismatches, %0d missing stores, 1 timeout",
				errorCount, missingCount);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic compareWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic compareCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	// Instruction encoders
	function automatic wordT encI(input opcodeT opc, input logic [2:0] f3, input regIdxT rd,
		input regIdxT rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic wordT encS(input regIdxT rs2, input regIdxT rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'h2, imm[4:0], STORE};
	endfunction

	function automatic wordT encB(input logic [2:0] f3, input regIdxT rs1, input regIdxT rs2,
		input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
	endfunction

	function automatic wordT encU(input regIdxT rd, input logic [19:0] upper);
		return {upper, rd, LUI};
	endfunction

	function automatic wordT encJ(input regIdxT rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
	endfunction

	function automatic logic [2:0] funct3Of(input aluOpT op);
		case (op)
			SLL: return 3'h1;
			SLT: return 3'h2;
			XOR: return 3'h4;
			SRL, SRA: return 3'h5;
			OR: return 3'h6;
			AND: return 3'h7;
			default: return 3'h0;
		endcase
	endfunction

	function automatic wordT encOp(input aluOpT op, input regIdxT rd, input regIdxT rs1,
		input regIdxT rs2);
		logic [6:0] f7;
		f7 = (op == SUB || op == SRA) ? 7'h20 : 7'h00;
		return {f7, rs2, rs1, funct3Of(op), rd, OP};
	endfunction

	// Expected result from the RV32I definitions
	function automatic wordT refAlu(input aluOpT op, input wordT a, input wordT b);
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			SLL: return a << b[4:0];
			SRL: return a >> b[4:0];
			SRA: return $signed(a) >>> b[4:0];
			default: return b;
		endcase
	endfunction

	task automatic emit(input wordT instr);
		imem[progLen] = instr;
		progLen++;
	endtask

	task automatic loadConst(input regIdxT rd, input wordT value);
		wordT upper;
		// Rounds so the sign-extended low part lands exactly
		upper = value + 32'h800;
		emit(encU(rd, upper[31:12]));
		emit(encI(OP_IMM, 3'h0, rd, rd, value[11:0]));
	endtask

	task automatic storeReg(input regIdxT rs, input wordT expected);
		emit(encS(rs, 5'd0, nextAddr[11:0]));
		expAddrs.push_back(nextAddr);
		expData.push_back(expected);
		nextAddr += 4;
	endtask

	task automatic startProgram();
		wordT addr;
		int i;
		// Harmless fill, ADDI x0 with the byte address
		for (i = 0; i < 128; i++) begin
			addr = i * 4;
			imem[i] = encI(OP_IMM, 3'h0, 5'd0, 5'd0, addr[11:0]);
		end
		@(posedge clk);
		reset <= 1'b1;
		startCycle = cycleCount;
		cycleLimit = 40;
		@(posedge clk);
		progLen = 0;
		nextAddr = '0;
		expAddrs.delete();
		expData.delete();
	endtask

	task automatic runProgram(input string name);
		// Final self-loop keeps the core parked
		emit(encJ(5'd0, 21'd0));
		repeat (4) begin
			@(negedge clk);
			compareWord("instrAddr", `RV_RESET_PC, instrAddr);
			compareWord("dataWrite", 32'd0, wordT'(dataWrite));
			@(posedge clk);
		end
		reset <= 1'b0;
		@(negedge clk);
		compareWord("instrAddr", `RV_RESET_PC, instrAddr);
		startCycle = cycleCount;
		cycleLimit = 4 * progLen + 20;
		while (storeData.size() < expData.size()) begin
			@(posedge clk);
		end
		// Room for any stray store to show up
		repeat (8) @(posedge clk);
		compareCount({name, " store count"}, expData.size(), storeData.size());
		foreach (expData[i]) begin
			if (i >= storeData.size()) begin
				$display("Test %s: store %0d to address %h never happened",
					name, i, expAddrs[i]);
				missingCount++;
			end else begin
				compareWord("dataAddr", expAddrs[i], storeAddrs[i]);
				compareWord("dataWriteData", expData[i], storeData[i]);
			end
		end
	endtask

	`include "rvCoreTests.svh"

	initial begin
		testReset();
		testAluChains();
		testLoadStore();
		testBranches();
		testJal();
		testZeroReg();
		$display("Errors: %0d mismatches, %0d missing stores", errorCount, missingCount);
		if (errorCount == 0 && missingCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
+incdir+tests
common/rvCorePkg.sv
source/instrDecoder.sv
source/regFile.sv
source/alu.sv
source/hazardUnit.sv
source/rvCore.sv
tests/rvCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP := rvCoreTb
FILELIST := verilog.f
OBJ_DIR := obj_dir
LOG := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := common/rvCore_config.svh tests/rvCoreTests.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run FAILED"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
